// File: build.f
starforce_pkg.sv
settings_if.sv
core_settings_regs.sv
reset_sequencer.sv
game_input_mapper.sv
video_formatter.sv
starforce_shell_top.sv
starforce_properties.sv
tb_starforce_shell.sv

// File: Bender.yml
package:
  name: starforce_shell

sources:
  - files:
      - starforce_pkg.sv
      - settings_if.sv
      - core_settings_regs.sv
      - reset_sequencer.sv
      - game_input_mapper.sv
      - video_formatter.sv
      - starforce_shell_top.sv
  - target: test
    files:
      - starforce_properties.sv
      - tb_starforce_shell.sv

// File: tb_starforce_shell.sv
//////////////////////////////////////////////////////////////////////
// testbench for the star force shell top level
// clock, reset, random stimulus, watchdog and closing report
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_starforce_shell;

    localparam realtime CLK_PERIOD     = 8.0;
    localparam int      HOLD_CYCLES    = 20;
    localparam int      COIN_CYCLES    = 12;
    localparam int      SETTING_ROUNDS = 4;
    localparam int      HOLD_WAIT      = 32;
    localparam int      READ_CYCLES    = 48;
    localparam int      TAIL_CYCLES    = 30;
    // phase lengths added up
    localparam int      STIM_CYCLES    = 3 + 8 * SETTING_ROUNDS + (12 + 2 * HOLD_WAIT) + 39 +
                                         READ_CYCLES + (23 + 2 * COIN_CYCLES) + TAIL_CYCLES;

    logic                          clk_74a;
    logic                          rst_n;
    logic                          host_reset_n;
    logic [31:0]                   bridge_addr;
    logic [31:0]                   bridge_wr_data;
    logic                          bridge_wr;
    logic [31:0]                   cmd_rd_data;
    logic [31:0]                   bridge_rd_data;
    logic                          dataslot_requestwrite;
    logic                          dataslot_allcomplete;
    logic                          core_reset;
    logic [15:0]                   cont1_key;
    starforce_pkg::control_word_t  controls;
    starforce_pkg::dip_word_t      dip_sw;
    logic                          core_hsync;
    logic                          core_vsync;
    logic                          core_hblank;
    logic                          core_vblank;
    starforce_pkg::rgb12_t         core_rgb;
    starforce_pkg::rgb24_t         video_rgb;
    logic                          video_de;
    logic                          video_hs;
    logic                          video_vs;

    int error_count = 0;
    int seed        = 32'hc0df;

    starforce_shell_top #(
        .RESET_HOLD_CYCLES (HOLD_CYCLES),
        .COIN_PULSE_CYCLES (COIN_CYCLES)
    ) dut0 (.*);

    bind starforce_shell_top starforce_properties #(
        .HOLD_CYCLES (RESET_HOLD_CYCLES),
        .COIN_CYCLES (COIN_PULSE_CYCLES)
    ) props0 (.*);

    initial begin
        clk_74a = 1'b0;
        forever #(CLK_PERIOD / 2) clk_74a = ~clk_74a;
    end

    // read data, colour, blanks and syncs change every cycle
    initial begin : background_stimulus
        logic [31:0] rnd;
        @(posedge rst_n);
        forever begin
            @(posedge clk_74a);
            rnd = $random(seed);
            core_rgb    <= rnd[11:0];
            core_hblank <= rnd[14:12] == 3'b000;
            core_vblank <= rnd[17:15] == 3'b000;
            core_hsync  <= rnd[18];
            core_vsync  <= rnd[20:19] == 2'b11;
            cmd_rd_data <= $random(seed);
        end
    end

    initial begin : watchdog
        repeat (4 * STIM_CYCLES) @(posedge clk_74a);
        $display("timeout: stimulus did not finish within %0d clock cycles", 4 * STIM_CYCLES);
        $display("Checks failed");
        $finish;
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk_74a);
    endtask

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_74a);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_wr      <= 1'b0;
    endtask

    task automatic dataslot_pulse(input logic request, input logic complete);
        @(posedge clk_74a);
        dataslot_requestwrite <= request;
        dataslot_allcomplete  <= complete;
        @(posedge clk_74a);
        dataslot_requestwrite <= 1'b0;
        dataslot_allcomplete  <= 1'b0;
    endtask

    // random buttons with the coin key held at a given level
    task automatic drive_keys(input logic coin, input int cycles);
        logic [31:0] rnd;
        repeat (cycles) begin
            @(posedge clk_74a);
            rnd = $random(seed);
            cont1_key <= {rnd[15], coin, rnd[13:0]};
        end
    endtask

    initial begin : main_stimulus
        logic [31:0] rnd;
        rst_n                 = 1'b0;
        host_reset_n          = 1'b1;
        bridge_addr           = 32'h0;
        bridge_wr_data        = 32'h0;
        bridge_wr             = 1'b0;
        cmd_rd_data           = 32'h0;
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete  = 1'b0;
        cont1_key             = 16'h0;
        core_hsync            = 1'b0;
        core_vsync            = 1'b0;
        core_hblank           = 1'b0;
        core_vblank           = 1'b0;
        core_rgb              = 12'h0;
        repeat (3) @(posedge clk_74a);
        rst_n <= 1'b1;

        for (int round = 0; round < SETTING_ROUNDS; round++) begin
            bridge_write(starforce_pkg::SET_LIVES, $random(seed));
            bridge_write(starforce_pkg::SET_DIFFICULTY, $random(seed));
            bridge_write(starforce_pkg::SET_BONUS, $random(seed));
            bridge_write(starforce_pkg::SET_DEMO_SOUNDS, $random(seed));
        end

        // second toggle lands inside the hold
        bridge_write(starforce_pkg::SET_RESET_TOGGLE, 32'h0);
        idle_cycles(6);
        bridge_write(starforce_pkg::SET_RESET_TOGGLE, 32'h0);
        idle_cycles(HOLD_WAIT);
        bridge_write(starforce_pkg::SET_RESET_TOGGLE, 32'h0);
        idle_cycles(HOLD_WAIT);

        dataslot_pulse(1'b1, 1'b0);
        idle_cycles(8);
        dataslot_pulse(1'b0, 1'b1);
        idle_cycles(4);
        dataslot_pulse(1'b1, 1'b1);
        idle_cycles(4);
        dataslot_pulse(1'b0, 1'b1);
        idle_cycles(4);
        @(posedge clk_74a);
        host_reset_n <= 1'b0;
        idle_cycles(5);
        @(posedge clk_74a);
        host_reset_n <= 1'b1;
        idle_cycles(4);

        // half of the reads hit the command page
        repeat (READ_CYCLES) begin
            @(posedge clk_74a);
            rnd = $random(seed);
            if (rnd[0]) begin
                bridge_addr <= {starforce_pkg::CMD_READ_PAGE, rnd[31:8]};
            end else begin
                bridge_addr <= rnd;
            end
        end

        drive_keys(1'b1, 3);
        drive_keys(1'b0, 4);
        drive_keys(1'b1, 2);
        drive_keys(1'b0, COIN_CYCLES + 6);
        drive_keys(1'b1, 2);
        drive_keys(1'b0, COIN_CYCLES + 6);

        idle_cycles(TAIL_CYCLES);
        $display("assertion failures: %0d", error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: starforce_properties.sv
//////////////////////////////////////////////////////////////////////
// concurrent assertions for the star force shell top level
// settings word, reset hold, download, read mux, controls, video
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module starforce_properties #(
    parameter int unsigned HOLD_CYCLES = 20,
    parameter int unsigned COIN_CYCLES = 12
) (
    input logic        clk_74a,
    input logic        rst_n,
    input logic        host_reset_n,
    input logic [31:0] bridge_addr,
    input logic [31:0] bridge_wr_data,
    input logic        bridge_wr,
    input logic [31:0] cmd_rd_data,
    input logic [31:0] bridge_rd_data,
    input logic        dataslot_requestwrite,
    input logic        dataslot_allcomplete,
    input logic        core_reset,
    input logic [15:0] cont1_key,
    input logic [6:0]  controls,
    input logic [15:0] dip_sw,
    input logic        core_hsync,
    input logic        core_vsync,
    input logic        core_hblank,
    input logic        core_vblank,
    input logic [11:0] core_rgb,
    input logic [23:0] video_rgb,
    input logic        video_de,
    input logic        video_hs,
    input logic        video_vs
);

    logic        tgl_wr;
    logic        run_q;
    logic        dl_model;
    logic [7:0]  quiet_cnt;
    logic [15:0] dip_exp;
    logic [31:0] rd_exp;
    logic [5:0]  ctrl_exp;
    logic        de_exp;
    logic [23:0] rgb_exp;
    logic        hs_prev;
    logic        vs_prev;
    logic        hs_exp;
    logic        vs_exp;

    assign tgl_wr = bridge_wr && (bridge_addr == starforce_pkg::SET_RESET_TOGGLE);
    // page F8 returns the command handler word
    assign rd_exp = (bridge_addr[31:24] == 8'hF8) ? cmd_rd_data : 32'h0;

    //////////////////////////////////////////////////////////////////////
    // expected values, one cycle behind the inputs
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        run_q <= rst_n;
        if (!rst_n) begin
            dl_model  <= 1'b0;
            quiet_cnt <= 8'd0;
            dip_exp   <= 16'h0000;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
        end else begin
            if (dataslot_requestwrite) begin
                dl_model <= 1'b1;
            end else if (dataslot_allcomplete) begin
                dl_model <= 1'b0;
            end
            // cycles since the last reset toggle write
            if (tgl_wr) begin
                quiet_cnt <= 8'd0;
            end else if (quiet_cnt != 8'hff) begin
                quiet_cnt <= quiet_cnt + 8'd1;
            end
            // fields land in the swapped byte layout of the core
            if (bridge_wr && bridge_addr == starforce_pkg::SET_LIVES) begin
                dip_exp[5:4] <= bridge_wr_data[1:0];
            end
            if (bridge_wr && bridge_addr == starforce_pkg::SET_DIFFICULTY) begin
                dip_exp[13:11] <= bridge_wr_data[2:0];
            end
            if (bridge_wr && bridge_addr == starforce_pkg::SET_BONUS) begin
                dip_exp[10:8] <= bridge_wr_data[2:0];
            end
            if (bridge_wr && bridge_addr == starforce_pkg::SET_DEMO_SOUNDS) begin
                dip_exp[7] <= bridge_wr_data[0];
            end
            hs_exp  <= core_hsync && !hs_prev;
            vs_exp  <= core_vsync && !vs_prev;
            hs_prev <= core_hsync;
            vs_prev <= core_vsync;
        end
        // up, down, left, right, fire, start
        ctrl_exp <= {cont1_key[0], cont1_key[1], cont1_key[2],
                     cont1_key[3], cont1_key[4], cont1_key[15]};
        de_exp   <= !core_hblank && !core_vblank;
        if (!core_hblank && !core_vblank) begin
            rgb_exp <= {core_rgb[11:8] * 8'h11, core_rgb[7:4] * 8'h11, core_rgb[3:0] * 8'h11};
        end else begin
            rgb_exp <= 24'h000000;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bridge side
    //////////////////////////////////////////////////////////////////////

    a_dip_word: assert property (@(posedge clk_74a) disable iff (!rst_n)
        dip_sw == dip_exp)
    else begin
        tb_starforce_shell.error_count++;
        $error("Error dip_sw got %h expected %h", $sampled(dip_sw), $sampled(dip_exp));
    end

    a_read_mux: assert property (@(posedge clk_74a) disable iff (!rst_n)
        bridge_rd_data == rd_exp)
    else begin
        tb_starforce_shell.error_count++;
        $error("Error bridge_rd_data got %h expected %h",
               $sampled(bridge_rd_data), $sampled(rd_exp));
    end

    // toggle seen in idle, hold starts two cycles later
    a_manual_hold: assert property (@(posedge clk_74a) disable iff (!rst_n)
        tgl_wr && !core_reset && !$past(tgl_wr) && !$past(tgl_wr, 2)
        |-> ##3 core_reset [*HOLD_CYCLES] ##1
            (!core_reset || $past(!host_reset_n) || $past(dl_model)))
    else begin
        tb_starforce_shell.error_count++;
        $error("manual reset hold did not last exactly %0d cycles", HOLD_CYCLES);
    end

    a_download_reset: assert property (@(posedge clk_74a) disable iff (!rst_n)
        dl_model |=> core_reset)
    else begin
        tb_starforce_shell.error_count++;
        $error("Error core_reset got %h expected %h during download", $sampled(core_reset), 1'b1);
    end

    a_host_reset: assert property (@(posedge clk_74a) disable iff (!rst_n)
        !host_reset_n |=> core_reset)
    else begin
        tb_starforce_shell.error_count++;
        $error("Error core_reset got %h expected %h after host reset", $sampled(core_reset), 1'b1);
    end

    // no host reset, no download and no hold left from a toggle
    a_reset_release: assert property (@(posedge clk_74a) disable iff (!rst_n)
        quiet_cnt > HOLD_CYCLES + 1 && $past(host_reset_n) && !$past(dl_model)
        |-> !core_reset)
    else begin
        tb_starforce_shell.error_count++;
        $error("Error core_reset got %h expected %h with no reset cause",
               $sampled(core_reset), 1'b0);
    end

    //////////////////////////////////////////////////////////////////////
    // controls and video
    //////////////////////////////////////////////////////////////////////

    a_control_bits: assert property (@(posedge clk_74a) disable iff (!rst_n)
        run_q |-> controls[6:1] == ctrl_exp)
    else begin
        tb_starforce_shell.error_count++;
        $error("Error controls[6:1] got %h expected %h", $sampled(controls[6:1]), $sampled(ctrl_exp));
    end

    a_coin_pulse: assert property (@(posedge clk_74a) disable iff (!rst_n)
        run_q && $fell(cont1_key[14]) && !controls[0]
        |=> controls[0] [*COIN_CYCLES] ##1 !controls[0])
    else begin
        tb_starforce_shell.error_count++;
        $error("coin pulse did not last exactly %0d cycles", COIN_CYCLES);
    end

    a_video_de: assert property (@(posedge clk_74a) disable iff (!rst_n)
        run_q |-> video_de == de_exp)
    else begin
        tb_starforce_shell.error_count++;
        $error("Error video_de got %h expected %h", $sampled(video_de), $sampled(de_exp));
    end

    a_video_rgb: assert property (@(posedge clk_74a) disable iff (!rst_n)
        run_q |-> video_rgb == rgb_exp)
    else begin
        tb_starforce_shell.error_count++;
        $error("Error video_rgb got %h expected %h", $sampled(video_rgb), $sampled(rgb_exp));
    end

    a_sync_pulses: assert property (@(posedge clk_74a) disable iff (!rst_n)
        run_q |-> video_hs == hs_exp && video_vs == vs_exp)
    else begin
        tb_starforce_shell.error_count++;
        $error("Error video_hs/video_vs got %h/%h expected %h/%h", $sampled(video_hs),
               $sampled(video_vs), $sampled(hs_exp), $sampled(vs_exp));
    end

    a_reset_values: assert property (@(posedge clk_74a)
        !rst_n |=> core_reset && !video_de && !video_hs && !video_vs &&
                   controls == 7'h00 && dip_sw == 16'h0000)
    else begin
        tb_starforce_shell.error_count++;
        $error("outputs did not take their reset values");
    end

endmodule

// File: starforce_shell_top.sv
//////////////////////////////////////////////////////////////////////
// star force shell top level
// settings registers, reset sequencer, input mapper, video formatter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module starforce_shell_top #(
    parameter int unsigned RESET_HOLD_CYCLES = starforce_pkg::DEFAULT_RESET_HOLD_CYCLES,
    parameter int unsigned COIN_PULSE_CYCLES = starforce_pkg::DEFAULT_COIN_PULSE_CYCLES
) (
    input  logic                          clk_74a,
    input  logic                          rst_n,
    input  logic                          host_reset_n,
    // bridge
    input  logic [31:0]                   bridge_addr,
    input  logic [31:0]                   bridge_wr_data,
    input  logic                          bridge_wr,
    input  logic [31:0]                   cmd_rd_data,
    output logic [31:0]                   bridge_rd_data,
    input  logic                          dataslot_requestwrite,
    input  logic                          dataslot_allcomplete,
    // core side
    output logic                          core_reset,
    input  logic [15:0]                   cont1_key,
    output starforce_pkg::control_word_t  controls,
    output starforce_pkg::dip_word_t      dip_sw,
    input  logic                          core_hsync,
    input  logic                          core_vsync,
    input  logic                          core_hblank,
    input  logic                          core_vblank,
    input  starforce_pkg::rgb12_t         core_rgb,
    // scaler
    output starforce_pkg::rgb24_t         video_rgb,
    output logic                          video_de,
    output logic                          video_hs,
    output logic                          video_vs
);

    settings_if settings_bus ();

    core_settings_regs u_regs (
        .clk_74a               (clk_74a),
        .rst_n                 (rst_n),
        .bridge_addr           (bridge_addr),
        .bridge_wr_data        (bridge_wr_data),
        .bridge_wr             (bridge_wr),
        .cmd_rd_data           (cmd_rd_data),
        .bridge_rd_data        (bridge_rd_data),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .settings              (settings_bus.regs)
    );

    reset_sequencer #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) u_reset (
        .clk_74a      (clk_74a),
        .rst_n        (rst_n),
        .host_reset_n (host_reset_n),
        .settings     (settings_bus.user),
        .core_reset   (core_reset)
    );

    game_input_mapper #(
        .COIN_PULSE_CYCLES (COIN_PULSE_CYCLES)
    ) u_input (
        .clk_74a   (clk_74a),
        .rst_n     (rst_n),
        .cont1_key (cont1_key),
        .settings  (settings_bus.user),
        .controls  (controls),
        .dip_sw    (dip_sw)
    );

    video_formatter u_video (
        .clk_74a     (clk_74a),
        .rst_n       (rst_n),
        .core_hsync  (core_hsync),
        .core_vsync  (core_vsync),
        .core_hblank (core_hblank),
        .core_vblank (core_vblank),
        .core_rgb    (core_rgb),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs)
    );

endmodule

// File: video_formatter.sv
//////////////////////////////////////////////////////////////////////
// colour expansion to 24 bit, data enable, sync edge pulses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module video_formatter (
    input  logic                  clk_74a,
    input  logic                  rst_n,
    input  logic                  core_hsync,
    input  logic                  core_vsync,
    input  logic                  core_hblank,
    input  logic                  core_vblank,
    input  starforce_pkg::rgb12_t core_rgb,
    output starforce_pkg::rgb24_t video_rgb,
    output logic                  video_de,
    output logic                  video_hs,
    output logic                  video_vs
);

    logic hs_prev;
    logic vs_prev;
    logic active;

    assign active = !(core_hblank || core_vblank);

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            video_de  <= 1'b0;
            video_rgb <= '0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
        end else begin
            video_de <= active;
            // each nibble doubled, black outside the active area
            if (active) begin
                video_rgb <= {{2{core_rgb[11:8]}}, {2{core_rgb[7:4]}}, {2{core_rgb[3:0]}}};
            end else begin
                video_rgb <= '0;
            end
            video_hs <= core_hsync && !hs_prev;
            video_vs <= core_vsync && !vs_prev;
            hs_prev  <= core_hsync;
            vs_prev  <= core_vsync;
        end
    end

endmodule

// File: game_input_mapper.sv
//////////////////////////////////////////////////////////////////////
// controller to core control word, coin pulse stretcher
// and the DIP switch word in core byte order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module game_input_mapper #(
    parameter int unsigned COIN_PULSE_CYCLES = starforce_pkg::DEFAULT_COIN_PULSE_CYCLES
) (
    input  logic                         clk_74a,
    input  logic                         rst_n,
    input  logic [15:0]                  cont1_key,
    settings_if.user                     settings,
    output starforce_pkg::control_word_t controls,
    output starforce_pkg::dip_word_t     dip_sw
);

    localparam int CNT_W = $clog2(COIN_PULSE_CYCLES + 1);

    logic [CNT_W-1:0] coin_cnt;
    logic             coin_prev;
    logic             coin_fall;

    // select key released
    assign coin_fall = coin_prev && !cont1_key[14];

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            controls[6:1] <= '0;
        end else begin
            controls[6:1] <= {cont1_key[0], cont1_key[1], cont1_key[2],
                              cont1_key[3], cont1_key[4], cont1_key[15]};
        end
    end

    // coin bit stays high for COIN_PULSE_CYCLES cycles
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            coin_prev   <= 1'b0;
            coin_cnt    <= '0;
            controls[0] <= 1'b0;
        end else begin
            coin_prev <= cont1_key[14];
            if (coin_cnt != '0) begin
                coin_cnt <= coin_cnt - 1'b1;
            end else if (controls[0]) begin
                controls[0] <= 1'b0;
            end else if (coin_fall) begin
                controls[0] <= 1'b1;
                coin_cnt    <= CNT_W'(COIN_PULSE_CYCLES - 1);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // dip word, bytes already swapped for the core
    //////////////////////////////////////////////////////////////////////

    assign dip_sw = {2'b00, settings.difficulty, settings.bonus,
                     settings.demo_sounds, 1'b0, settings.lives, 4'b0000};

endmodule

// File: reset_sequencer.sv
//////////////////////////////////////////////////////////////////////
// manual reset hold counter and the combined core reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module reset_sequencer #(
    parameter int unsigned RESET_HOLD_CYCLES = starforce_pkg::DEFAULT_RESET_HOLD_CYCLES
) (
    input  logic     clk_74a,
    input  logic     rst_n,
    input  logic     host_reset_n,
    settings_if.user settings,
    output logic     core_reset
);

    localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

    starforce_pkg::reset_state_e state;
    logic [CNT_W-1:0]            hold_cnt;
    logic                        toggle_last;

    // toggles seen while holding are simply absorbed
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            state       <= starforce_pkg::RST_IDLE;
            hold_cnt    <= '0;
            toggle_last <= 1'b0;
        end else begin
            toggle_last <= settings.reset_toggle;
            case (state)
                starforce_pkg::RST_IDLE: begin
                    if (settings.reset_toggle != toggle_last) begin
                        state    <= starforce_pkg::RST_HOLD;
                        hold_cnt <= '0;
                    end
                end
                starforce_pkg::RST_HOLD: begin
                    // last hold cycle
                    if (hold_cnt == CNT_W'(RESET_HOLD_CYCLES - 1)) begin
                        state <= starforce_pkg::RST_IDLE;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: state <= starforce_pkg::RST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            core_reset <= 1'b1;
        end else begin
            core_reset <= !host_reset_n || settings.download ||
                          (state == starforce_pkg::RST_HOLD);
        end
    end

endmodule

// File: core_settings_regs.sv
//////////////////////////////////////////////////////////////////////
// bridge-written settings registers, ROM download flag
// and the bridge read-data multiplexer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module core_settings_regs (
    input  logic        clk_74a,
    input  logic        rst_n,
    input  logic [31:0] bridge_addr,
    input  logic [31:0] bridge_wr_data,
    input  logic        bridge_wr,
    input  logic [31:0] cmd_rd_data,
    output logic [31:0] bridge_rd_data,
    input  logic        dataslot_requestwrite,
    input  logic        dataslot_allcomplete,
    settings_if.regs    settings
);

    starforce_pkg::lives_t      lives_q;
    starforce_pkg::difficulty_t difficulty_q;
    starforce_pkg::bonus_t      bonus_q;
    logic                       demo_sounds_q;
    logic                       reset_toggle_q;
    logic                       download_q;

    // exact address match, low bits of the write word
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            lives_q        <= '0;
            difficulty_q   <= '0;
            bonus_q        <= '0;
            demo_sounds_q  <= 1'b0;
            reset_toggle_q <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                starforce_pkg::SET_LIVES:        lives_q        <= bridge_wr_data[1:0];
                starforce_pkg::SET_DIFFICULTY:   difficulty_q   <= bridge_wr_data[2:0];
                starforce_pkg::SET_BONUS:        bonus_q        <= bridge_wr_data[2:0];
                starforce_pkg::SET_DEMO_SOUNDS:  demo_sounds_q  <= bridge_wr_data[0];
                starforce_pkg::SET_RESET_TOGGLE: reset_toggle_q <= ~reset_toggle_q;
                default: ;
            endcase
        end
    end

    // request wins over completion
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            download_q <= 1'b0;
        end else if (dataslot_requestwrite) begin
            download_q <= 1'b1;
        end else if (dataslot_allcomplete) begin
            download_q <= 1'b0;
        end
    end

    always_comb begin
        if (bridge_addr[31:24] == starforce_pkg::CMD_READ_PAGE) begin
            bridge_rd_data = cmd_rd_data;
        end else begin
            bridge_rd_data = '0;
        end
    end

    assign settings.lives        = lives_q;
    assign settings.difficulty   = difficulty_q;
    assign settings.bonus        = bonus_q;
    assign settings.demo_sounds  = demo_sounds_q;
    assign settings.reset_toggle = reset_toggle_q;
    assign settings.download     = download_q;

endmodule

// File: settings_if.sv
//////////////////////////////////////////////////////////////////////
// operator settings plus reset toggle and download flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface settings_if;

    starforce_pkg::lives_t      lives;
    starforce_pkg::difficulty_t difficulty;
    starforce_pkg::bonus_t      bonus;
    logic                       demo_sounds;
    logic                       reset_toggle;
    logic                       download;

    // register block side
    modport regs (
        output lives, difficulty, bonus, demo_sounds, reset_toggle, download
    );

    // consumers of the settings
    modport user (
        input lives, difficulty, bonus, demo_sounds, reset_toggle, download
    );

endinterface

// File: starforce_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared definitions for the star force shell
// bridge setting addresses, read page, field types, reset states
// and default timing constants
//////////////////////////////////////////////////////////////////////

package starforce_pkg;

    //////////////////////////////////////////////////////////////////////
    // bridge addresses
    //////////////////////////////////////////////////////////////////////

    // exact-match write addresses of the settings registers
    typedef enum logic [31:0] {
        SET_LIVES        = 32'h2000_0000,
        SET_DIFFICULTY   = 32'h3000_0000,
        SET_BONUS        = 32'h4000_0000,
        SET_DEMO_SOUNDS  = 32'h5000_0000,
        SET_RESET_TOGGLE = 32'h8000_0000
    } setting_addr_e;

    // top address byte served by the command handler
    localparam logic [7:0] CMD_READ_PAGE = 8'hF8;

    //////////////////////////////////////////////////////////////////////
    // field types
    //////////////////////////////////////////////////////////////////////

    typedef logic [1:0]  lives_t;
    typedef logic [2:0]  difficulty_t;
    typedef logic [2:0]  bonus_t;
    typedef logic [15:0] dip_word_t;

    // red [11:8], green [7:4], blue [3:0]
    typedef logic [11:0] rgb12_t;
    typedef logic [23:0] rgb24_t;

    // up, down, left, right, fire, start, coin from bit 6 down
    typedef logic [6:0]  control_word_t;

    typedef enum logic {
        RST_IDLE,
        RST_HOLD
    } reset_state_e;

    // roughly 28 ms and 14 ms at 74.25 MHz
    localparam int unsigned DEFAULT_RESET_HOLD_CYCLES = 2097151;
    localparam int unsigned DEFAULT_COIN_PULSE_CYCLES = 1048575;

endpackage
